//--- Bender.yml
package:
  name: chip8

sources:
  - logic/chip8_pkg.sv
  - logic/chip8_if.sv
  - logic/chip8_regs.sv
  - logic/chip8_keypad.sv
  - logic/chip8_control.sv
  - logic/chip8_mover.sv
  - logic/chip8_top.sv
  - target: test
    files:
      - verif/chip8_tb.sv

//--- logic/chip8_control.sv
module chip8_control (
  input  logic                clk,
  input  logic                rst_i,
  input  logic [15:0]         key_matrix_i,
  input  logic                key_release_i,
  input  chip8_pkg::reg_idx_t key_idx_i,
  reg_port_if.master          rp,
  xfer_if.master              xf,
  output logic                halted_o
);
  import chip8_pkg::*;

  state_e state_q;
  addr_t pc_q;
  addr_t stack_q [STACK_DEPTH];
  logic [$clog2(STACK_DEPTH):0] sp_q;     // One bit wider so a full stack is visible.
  logic [$clog2(STACK_DEPTH)-1:0] push_idx;
  logic [$clog2(STACK_DEPTH)-1:0] pop_idx;
  logic [15:0] ir_q;
  opcode_e op;
  reg_idx_t x;
  reg_idx_t y;
  logic [3:0] n;
  byte_t kk;
  addr_t nnn;
  logic [DATA_W:0] add_sum;
  logic skip;
  logic illegal;

  assign op = opcode_e'(ir_q[15:12]);
  assign x = ir_q[11:8];
  assign y = ir_q[7:4];
  assign n = ir_q[3:0];
  assign kk = ir_q[7:0];
  assign nnn = addr_t'(ir_q[11:0]);
  assign add_sum = {1'b0, rp.vx} + {1'b0, rp.vy};
  assign push_idx = sp_q[$clog2(STACK_DEPTH)-1:0];
  assign pop_idx = push_idx - 1'b1;
  assign halted_o = (state_q == HALT);
  assign xf.store_data = rp.vy;

  always_comb
  begin
    skip = 1'b0;
    illegal = 1'b0;
    case (op)
      SYS: illegal = (ir_q != 16'h00EE); // Only the return survives in this group.
      SE_IMM: skip = (rp.vx == kk);
      SNE_IMM: skip = (rp.vx != kk);
      SE_REG:
        begin
          skip = (rp.vx == rp.vy);
          illegal = (n != 4'h0);
        end
      SNE_REG:
        begin
          skip = (rp.vx != rp.vy);
          illegal = (n != 4'h0);
        end
      ALU: illegal = (n > 4'h7) && (n != 4'hE);
      SKEY:
        if (kk == 8'h9E)
          skip = key_matrix_i[rp.vx[3:0]];
        else if (kk == 8'hA1)
          skip = !key_matrix_i[rp.vx[3:0]];
        else
          illegal = 1'b1;
      MISC:
        case (kk)
          8'h07, 8'h0A, 8'h15, 8'h18, 8'h1E, 8'h29, 8'h33, 8'h55, 8'h65: illegal = 1'b0;
          default: illegal = 1'b1;
        endcase
      RND, DRW: illegal = 1'b1;
      default: ;
    endcase
  end

  always_comb
  begin
    rp.rd_x_sel = x;
    rp.rd_y_sel = (state_q == XFER) ? xf.store_idx : y; // Stores read through the y port.
    rp.wr_en = 1'b0;
    rp.wr_sel = x;
    rp.wr_data = '0;
    rp.vf_wr_en = 1'b0;
    rp.vf_data = '0;
    rp.i_wr_en = 1'b0;
    rp.i_data = rp.i_val + addr_t'(x) + addr_t'(1);
    rp.dt_wr_en = 1'b0;
    rp.st_wr_en = 1'b0;
    xf.start = 1'b0;
    xf.op = FETCH_IR;
    xf.addr = pc_q;
    xf.count = reg_idx_t'(1);
    xf.bcd_value = rp.vx;
    case (state_q)
      FETCH: xf.start = 1'b1;
      EXEC:
        case (op)
          LD_IMM:
            begin
              rp.wr_en = 1'b1;
              rp.wr_data = kk;
            end
          ADD_IMM:
            begin
              rp.wr_en = 1'b1;
              rp.wr_data = rp.vx + kk;
            end
          ALU:
            begin
              rp.wr_en = 1'b1;
              rp.vf_wr_en = (n >= 4'h4);
              case (n)
                4'h0: rp.wr_data = rp.vy;
                4'h1: rp.wr_data = rp.vx | rp.vy;
                4'h2: rp.wr_data = rp.vx & rp.vy;
                4'h3: rp.wr_data = rp.vx ^ rp.vy;
                4'h4:
                  begin
                    rp.wr_data = add_sum[DATA_W-1:0];
                    rp.vf_data = byte_t'(add_sum[DATA_W]);
                  end
                4'h5:
                  begin
                    rp.wr_data = rp.vx - rp.vy;
                    rp.vf_data = byte_t'(rp.vx >= rp.vy); // Set when no borrow.
                  end
                4'h6:
                  begin
                    rp.wr_data = rp.vx >> 1;
                    rp.vf_data = byte_t'(rp.vx[0]);
                  end
                4'h7:
                  begin
                    rp.wr_data = rp.vy - rp.vx;
                    rp.vf_data = byte_t'(rp.vy >= rp.vx);
                  end
                4'hE:
                  begin
                    rp.wr_data = rp.vx << 1;
                    rp.vf_data = byte_t'(rp.vx[DATA_W-1]);
                  end
                default:
                  begin
                    rp.wr_en = 1'b0;
                    rp.vf_wr_en = 1'b0;
                  end
              endcase
            end
          LD_I:
            begin
              rp.i_wr_en = 1'b1;
              rp.i_data = nnn;
            end
          MISC:
            begin
              xf.addr = rp.i_val;
              xf.count = x;
              case (kk)
                8'h07:
                  begin
                    rp.wr_en = 1'b1;
                    rp.wr_data = rp.dt_val;
                  end
                8'h15:
                  begin
                    rp.dt_wr_en = 1'b1;
                    rp.wr_data = rp.vx;
                  end
                8'h18:
                  begin
                    rp.st_wr_en = 1'b1;
                    rp.wr_data = rp.vx;
                  end
                8'h1E:
                  begin
                    rp.i_wr_en = 1'b1;
                    rp.i_data = rp.i_val + addr_t'(rp.vx);
                  end
                8'h29:
                  begin
                    rp.i_wr_en = 1'b1;
                    rp.i_data = addr_t'(rp.vx) * addr_t'(FONT_STRIDE);
                  end
                8'h33:
                  begin
                    xf.start = 1'b1;
                    xf.op = STORE_BCD;
                    xf.count = reg_idx_t'(2);
                  end
                8'h55:
                  begin
                    xf.start = 1'b1;
                    xf.op = STORE_REGS;
                    rp.i_wr_en = 1'b1;
                  end
                8'h65:
                  begin
                    xf.start = 1'b1;
                    xf.op = LOAD_REGS;
                    rp.i_wr_en = 1'b1;
                  end
                default: ;
              endcase
            end
          default: ;
        endcase
      XFER:
        if (xf.byte_valid)
        begin
          rp.wr_en = 1'b1;
          rp.wr_sel = xf.byte_idx;
          rp.wr_data = xf.byte_data;
        end
      KEYWAIT:
        if (key_release_i)
        begin
          rp.wr_en = 1'b1;
          rp.wr_data = byte_t'(key_idx_i);
        end
      default: ;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst_i)
    begin
      state_q <= FETCH;
      pc_q <= PC_RESET;
      sp_q <= '0;
    end
    else
    begin
      case (state_q)
        FETCH:
          begin
            pc_q <= pc_q + addr_t'(2);
            state_q <= WAIT_IR;
          end
        WAIT_IR:
          if (xf.done)
            state_q <= EXEC;
        EXEC:
          if (illegal)
            state_q <= HALT;
          else
          begin
            state_q <= FETCH;
            if (skip)
              pc_q <= pc_q + addr_t'(2);
            case (op)
              SYS:
                begin
                  pc_q <= stack_q[pop_idx];
                  sp_q <= sp_q - 1'b1;
                end
              JP: pc_q <= nnn;
              CALL:
                begin
                  pc_q <= nnn;
                  sp_q <= sp_q + 1'b1;
                end
              JP_V0: pc_q <= nnn + addr_t'(rp.v0);
              MISC:
                if (kk == 8'h0A)
                  state_q <= KEYWAIT;
                else if (kk == 8'h33 || kk == 8'h55 || kk == 8'h65)
                  state_q <= XFER;
              default: ;
            endcase
          end
        XFER:
          if (xf.done)
            state_q <= FETCH;
        KEYWAIT:
          if (key_release_i)
            state_q <= FETCH;
        default: ; // HALT holds until reset.
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (state_q == WAIT_IR && xf.byte_valid)
    begin
      if (xf.byte_idx[0])
        ir_q[7:0] <= xf.byte_data;
      else
        ir_q[15:8] <= xf.byte_data;
    end
    if (state_q == EXEC && op == CALL && !illegal)
      stack_q[push_idx] <= pc_q; // PC already points past the call.
  end

  assert property (@(posedge clk) disable iff (rst_i)
    (state_q == EXEC && op == CALL) |-> (sp_q < STACK_DEPTH))
    else $error("Stack overflow on CALL at PC %h.", pc_q);

  assert property (@(posedge clk) disable iff (rst_i)
    (state_q == EXEC && ir_q == 16'h00EE) |-> (sp_q != '0))
    else $error("Return without a matching CALL at PC %h.", pc_q);

endmodule

//--- logic/chip8_if.sv
interface reg_port_if;
  import chip8_pkg::*;

  reg_idx_t rd_x_sel;
  reg_idx_t rd_y_sel;
  byte_t vx;
  byte_t vy;
  byte_t v0;
  logic wr_en;
  reg_idx_t wr_sel;
  byte_t wr_data; // Also the load value for both timers.
  logic vf_wr_en;
  byte_t vf_data;
  logic i_wr_en;
  addr_t i_data;
  addr_t i_val;
  logic dt_wr_en;
  logic st_wr_en;
  byte_t dt_val;

  modport master (
    output rd_x_sel, rd_y_sel, wr_en, wr_sel, wr_data, vf_wr_en, vf_data,
    output i_wr_en, i_data, dt_wr_en, st_wr_en,
    input vx, vy, v0, i_val, dt_val
  );

  modport target (
    input rd_x_sel, rd_y_sel, wr_en, wr_sel, wr_data, vf_wr_en, vf_data,
    input i_wr_en, i_data, dt_wr_en, st_wr_en,
    output vx, vy, v0, i_val, dt_val
  );
endinterface

interface xfer_if;
  import chip8_pkg::*;

  logic start;
  xfer_e op;
  addr_t addr;
  reg_idx_t count; // Index of the last byte, so count+1 bytes move.
  byte_t bcd_value;
  logic busy;
  logic byte_valid;
  reg_idx_t byte_idx;
  byte_t byte_data;
  reg_idx_t store_idx;
  byte_t store_data;
  logic done;

  modport master (
    output start, op, addr, count, bcd_value, store_data,
    input busy, byte_valid, byte_idx, byte_data, store_idx, done
  );

  modport mover (
    input start, op, addr, count, bcd_value, store_data,
    output busy, byte_valid, byte_idx, byte_data, store_idx, done
  );
endinterface

//--- logic/chip8_keypad.sv
module chip8_keypad (
  input  logic                clk,
  input  logic                rst_i,
  input  logic [15:0]         key_matrix_i,
  output logic                release_o,
  output chip8_pkg::reg_idx_t key_idx_o
);
  import chip8_pkg::*;

  logic any_down_q;

  always_ff @(posedge clk)
  begin
    if (rst_i)
    begin
      any_down_q <= 1'b0;
      release_o <= 1'b0;
    end
    else
    begin
      any_down_q <= |key_matrix_i;
      release_o <= any_down_q && (key_matrix_i == '0); // All keys up after a press.
    end
  end

  // Later keys in the loop override earlier ones, so the highest pressed key is kept.
  always_ff @(posedge clk)
  begin
    for (int k = 0; k < 16; k++)
    begin
      if (key_matrix_i[k])
        key_idx_o <= reg_idx_t'(k);
    end
  end

endmodule

//--- logic/chip8_mover.sv
module chip8_mover (
  input  logic             clk,
  input  logic             rst_i,
  input  chip8_pkg::byte_t ram_dout_i,
  xfer_if.mover            xf,
  output chip8_pkg::addr_t ram_addr_o,
  output chip8_pkg::byte_t ram_din_o,
  output logic             ram_we_o
);
  import chip8_pkg::*;

  xfer_e op_q;
  addr_t base_q;
  reg_idx_t idx_q;
  reg_idx_t last_q;
  reg_idx_t rd_idx_q;
  byte_t bcd_q;
  logic active_q;     // Addresses are still being issued.
  logic rd_valid_q;   // RAM data for rd_idx_q arrives this cycle.
  logic is_store;
  logic last_issue;

  assign is_store = (op_q == STORE_REGS) || (op_q == STORE_BCD);
  assign last_issue = active_q && (idx_q == last_q);

  assign ram_addr_o = base_q + addr_t'(idx_q);
  assign ram_we_o = active_q && is_store;
  assign ram_din_o = (op_q == STORE_BCD) ? bcd_digit(bcd_q, idx_q[1:0]) : xf.store_data;

  assign xf.busy = active_q || rd_valid_q;
  assign xf.byte_valid = rd_valid_q;
  assign xf.byte_idx = rd_idx_q;
  assign xf.byte_data = ram_dout_i;
  assign xf.store_idx = idx_q;
  assign xf.done = is_store ? last_issue : (rd_valid_q && rd_idx_q == last_q);

  always_ff @(posedge clk)
  begin
    if (rst_i)
    begin
      active_q <= 1'b0;
      rd_valid_q <= 1'b0;
      op_q <= FETCH_IR;
      idx_q <= '0;
    end
    else
    begin
      rd_valid_q <= active_q && !is_store;
      if (xf.start)
      begin
        active_q <= 1'b1;
        op_q <= xf.op;
        idx_q <= '0;
      end
      else if (active_q)
      begin
        idx_q <= idx_q + 1'b1;
        if (last_issue)
          active_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    rd_idx_q <= idx_q;
    if (xf.start)
    begin
      base_q <= xf.addr;
      last_q <= xf.count;
      bcd_q <= xf.bcd_value;
    end
  end

  assert property (@(posedge clk) disable iff (rst_i) xf.start |-> !xf.busy)
    else $error("Transfer started while the previous one was still running.");

endmodule

//--- logic/chip8_pkg.sv
package chip8_pkg;

  localparam int ADDR_W = 16;
  localparam int DATA_W = 8;
  localparam int REG_IDX_W = 4;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] byte_t;
  typedef logic [REG_IDX_W-1:0] reg_idx_t;

  localparam addr_t PC_RESET = 16'h0200;
  localparam int STACK_DEPTH = 8;
  localparam int FONT_STRIDE = 5; // Bytes per glyph, glyphs start at address 0.
  localparam reg_idx_t VF_IDX = 4'hF;

  typedef enum logic [2:0] {
    FETCH,
    WAIT_IR,
    EXEC,
    XFER,
    KEYWAIT,
    HALT
  } state_e;

  // The order follows the top nibble of the instruction.
  typedef enum logic [3:0] {
    SYS, JP, CALL, SE_IMM, SNE_IMM, SE_REG, LD_IMM, ADD_IMM,
    ALU, SNE_REG, LD_I, JP_V0, RND, DRW, SKEY, MISC
  } opcode_e;

  typedef enum logic [1:0] {
    FETCH_IR,
    STORE_REGS,
    LOAD_REGS,
    STORE_BCD
  } xfer_e;

  // Position 0 gives the hundreds, 1 the tens and 2 the ones.
  function automatic byte_t bcd_digit(input byte_t value, input logic [1:0] pos);
    byte_t digit;
    case (pos)
      2'd0: digit = value / 8'd100;
      2'd1: digit = (value / 8'd10) % 8'd10;
      default: digit = value % 8'd10;
    endcase
    return digit;
  endfunction

endpackage

//--- logic/chip8_regs.sv
module chip8_regs (
  input  logic       clk,
  input  logic       rst_i,
  input  logic       vsync_i,
  reg_port_if.target rp,
  output logic       st_nonzero_o
);
  import chip8_pkg::*;

  byte_t v_q [2**REG_IDX_W];
  addr_t i_q;
  byte_t tmr_q [2];      // Entry 0 is the delay timer, entry 1 the sound timer.
  logic [1:0] tmr_load;
  logic vsync_q;
  logic vsync_tick;

  assign vsync_tick = vsync_i && !vsync_q;
  assign tmr_load = {rp.st_wr_en, rp.dt_wr_en};

  assign rp.vx = v_q[rp.rd_x_sel];
  assign rp.vy = v_q[rp.rd_y_sel];
  assign rp.v0 = v_q[0];
  assign rp.i_val = i_q;
  assign rp.dt_val = tmr_q[0];
  assign st_nonzero_o = (tmr_q[1] != '0);

  always_ff @(posedge clk)
  begin
    if (rst_i)
    begin
      for (int k = 0; k < 2**REG_IDX_W; k++)
        v_q[k] <= '0;
      i_q <= '0;
      tmr_q[0] <= '0;
      tmr_q[1] <= '0;
      vsync_q <= 1'b0;
    end
    else
    begin
      vsync_q <= vsync_i;
      if (rp.wr_en)
        v_q[rp.wr_sel] <= rp.wr_data;
      if (rp.vf_wr_en)
        v_q[VF_IDX] <= rp.vf_data; // Comes last so the flag wins over a result in VF.
      if (rp.i_wr_en)
        i_q <= rp.i_data;
      for (int k = 0; k < 2; k++)
      begin
        if (tmr_load[k])
          tmr_q[k] <= rp.wr_data;
        else if (vsync_tick && tmr_q[k] != '0)
          tmr_q[k] <= tmr_q[k] - 1'b1;
      end
    end
  end

  // A load in the same cycle as a frame tick keeps the loaded value.
  for (genvar t = 0; t < 2; t++)
  begin : g_tmr_chk
    assert property (@(posedge clk) disable iff (rst_i)
      (tmr_load[t] && vsync_tick) |=> (tmr_q[t] == $past(rp.wr_data)))
      else $error("Timer %0d lost its load to a vsync decrement.", t);
  end

endmodule

//--- logic/chip8_top.sv
module chip8_top (
  input  logic             clk,
  input  logic             rst_i,
  input  logic             vsync_i,
  input  logic [15:0]      key_matrix_i,
  input  chip8_pkg::byte_t ram_dout_i,
  output chip8_pkg::addr_t ram_addr_o,
  output chip8_pkg::byte_t ram_din_o,
  output logic             ram_we_o,
  output logic             beep_o,
  output logic             halted_o
);
  import chip8_pkg::*;

  logic key_release;
  reg_idx_t key_idx;

  reg_port_if rp ();
  xfer_if xf ();

  chip8_control u_control (
    .clk           (clk),
    .rst_i         (rst_i),
    .key_matrix_i  (key_matrix_i),
    .key_release_i (key_release),
    .key_idx_i     (key_idx),
    .rp            (rp),
    .xf            (xf),
    .halted_o      (halted_o)
  );

  chip8_regs u_regs (
    .clk          (clk),
    .rst_i        (rst_i),
    .vsync_i      (vsync_i),
    .rp           (rp),
    .st_nonzero_o (beep_o)   // The beeper sounds while the sound timer runs.
  );

  chip8_mover u_mover (
    .clk        (clk),
    .rst_i      (rst_i),
    .ram_dout_i (ram_dout_i),
    .xf         (xf),
    .ram_addr_o (ram_addr_o),
    .ram_din_o  (ram_din_o),
    .ram_we_o   (ram_we_o)
  );

  chip8_keypad u_keypad (
    .clk          (clk),
    .rst_i        (rst_i),
    .key_matrix_i (key_matrix_i),
    .release_o    (key_release),
    .key_idx_o    (key_idx)
  );

endmodule

//--- project.f
logic/chip8_pkg.sv
logic/chip8_if.sv
logic/chip8_regs.sv
logic/chip8_keypad.sv
logic/chip8_control.sv
logic/chip8_mover.sv
logic/chip8_top.sv
verif/chip8_tb.sv

//--- verif/chip8_tb.sv
module chip8_tb;
  import chip8_pkg::*;

  logic clk;
  logic rst_i;
  logic vsync_i;
  logic [15:0] key_matrix_i;
  byte_t ram_dout_i;
  addr_t ram_addr_o;
  byte_t ram_din_o;
  logic ram_we_o;
  logic beep_o;
  logic halted_o;

  byte_t mem [0:65535];
  addr_t load_ptr;
  addr_t last_wr_addr;
  int errors;
  int unsigned seed_ret;

  chip8_top dut (
    .clk          (clk),
    .rst_i        (rst_i),
    .vsync_i      (vsync_i),
    .key_matrix_i (key_matrix_i),
    .ram_dout_i   (ram_dout_i),
    .ram_addr_o   (ram_addr_o),
    .ram_din_o    (ram_din_o),
    .ram_we_o     (ram_we_o),
    .beep_o       (beep_o),
    .halted_o     (halted_o)
  );

  always #4 clk = ~clk;

  // Byte RAM with one cycle of read latency.
  always @(posedge clk)
  begin
    if (ram_we_o)
    begin
      mem[ram_addr_o] <= ram_din_o;
      last_wr_addr <= ram_addr_o;
    end
    ram_dout_i <= mem[ram_addr_o];
  end

  task automatic abort_run(input string why);
    errors++;
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1, "Stopping at the first error.");
  endtask

  task automatic check_byte(input string name, input byte_t got, input byte_t exp);
    if (got !== exp)
      abort_run($sformatf("FAIL %s: got 0x%h, expected 0x%h", name, got, exp));
  endtask

  task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    if (got !== exp)
      abort_run($sformatf("FAIL %s: got 0x%h, expected 0x%h", name, got, exp));
  endtask

  task automatic check_mem(input addr_t a, input byte_t exp);
    check_byte($sformatf("ram[0x%h]", a), mem[a], exp);
  endtask

  // Holds the core in reset and clears RAM before a new program is placed.
  task automatic start_program();
    @(negedge clk);
    rst_i = 1'b1;
    for (int a = 0; a < 65536; a++)
      mem[a] = '0;
    load_ptr = PC_RESET;
    last_wr_addr = '0;
  endtask

  task automatic emit(input logic [15:0] word);
    mem[load_ptr] = word[15:8];
    mem[load_ptr + 16'd1] = word[7:0];
    load_ptr = load_ptr + 16'd2;
  endtask

  task automatic apply_reset();
    rst_i = 1'b1;
    repeat (10) @(negedge clk);
    rst_i = 1'b0;
  endtask

  task automatic wait_for_halt(input int max_cycles);
    int cnt;
    cnt = 0;
    while (!halted_o)
    begin
      @(negedge clk);
      cnt++;
      if (cnt > max_cycles)
        abort_run("Timed out waiting for the core to halt.");
    end
  endtask

  task automatic wait_for_beep(input int max_cycles);
    int cnt;
    cnt = 0;
    while (!beep_o)
    begin
      @(negedge clk);
      cnt++;
      if (cnt > max_cycles)
        abort_run("Timed out waiting for the beeper to start.");
    end
  endtask

  task automatic pulse_vsync();
    vsync_i = 1'b1;
    repeat (2) @(negedge clk);
    vsync_i = 1'b0;
    repeat (2) @(negedge clk);
  endtask

  task automatic test_alu_flags();
    int a;
    int b;
    byte_t exp [13];
    a = $urandom_range(0, 255);
    b = $urandom_range(0, 255);
    exp[0] = 8'h00;
    exp[1] = byte_t'(a);
    exp[2] = byte_t'(b);
    exp[3] = byte_t'(a + b);
    exp[4] = (a + b > 255) ? 8'h01 : 8'h00;
    exp[5] = byte_t'(a - b);
    exp[6] = (a >= b) ? 8'h01 : 8'h00; // VF set when there is no borrow.
    exp[7] = byte_t'(b - a);
    exp[8] = (b >= a) ? 8'h01 : 8'h00;
    exp[9] = byte_t'(a / 2);
    exp[10] = byte_t'(a % 2);
    exp[11] = byte_t'(a * 2);
    exp[12] = byte_t'(a / 128);
    start_program();
    emit({8'h61, exp[1]});
    emit({8'h62, exp[2]});
    emit(16'h8310);
    emit(16'h8324);
    emit(16'h84F0);
    emit(16'h8510);
    emit(16'h8525);
    emit(16'h86F0);
    emit(16'h8710);
    emit(16'h8727);
    emit(16'h88F0);
    emit(16'h8910);
    emit(16'h8906);
    emit(16'h8AF0);
    emit(16'h8B10);
    emit(16'h8B0E);
    emit(16'h8CF0);
    emit(16'hA300);
    emit(16'hFC55);
    emit(16'hFFFF);
    apply_reset();
    wait_for_halt(500);
    for (int k = 0; k < 13; k++)
      check_mem(16'h0300 + addr_t'(k), exp[k]);
  endtask

  task automatic test_control_flow();
    byte_t exp [8];
    exp = '{8'h04, 8'hA1, 8'h00, 8'hB3, 8'h00, 8'h00, 8'hC6, 8'h00};
    start_program();
    emit(16'h6004);
    emit(16'h2300); // Subroutine sets V1 and returns.
    emit(16'h31A1);
    emit(16'h62EE);
    emit(16'h3100);
    emit(16'h63B3);
    emit(16'h1212);
    emit(16'h64EE);
    emit(16'h64EE);
    emit(16'hB214); // Lands on 0x218 with V0 = 4.
    emit(16'h65EE);
    emit(16'h65EE);
    emit(16'h66C6);
    emit(16'hA400);
    emit(16'hF655);
    emit(16'hFFFF);
    load_ptr = 16'h0300;
    emit(16'h61A1);
    emit(16'h00EE);
    apply_reset();
    wait_for_halt(500);
    for (int k = 0; k < 8; k++)
      check_mem(16'h0400 + addr_t'(k), exp[k]);
    check_addr("last write address", last_wr_addr, 16'h0406);
  endtask

  task automatic test_memory_xfer();
    int r;
    byte_t src [4];
    r = $urandom_range(0, 255);
    start_program();
    for (int k = 0; k < 4; k++)
    begin
      src[k] = byte_t'($urandom_range(0, 255));
      mem[16'h0310 + addr_t'(k)] = src[k];
    end
    emit({8'h61, byte_t'(r)});
    emit(16'hA300);
    emit(16'hF133);
    emit(16'hA310);
    emit(16'hF365);
    emit(16'hF355); // I has moved to 0x314 by now.
    emit(16'hFFFF);
    apply_reset();
    wait_for_halt(500);
    check_mem(16'h0300, byte_t'(r / 100));
    check_mem(16'h0301, byte_t'((r / 10) % 10));
    check_mem(16'h0302, byte_t'(r % 10));
    for (int k = 0; k < 4; k++)
      check_mem(16'h0314 + addr_t'(k), src[k]);
    check_addr("last write address", last_wr_addr, 16'h0317);
  endtask

  task automatic test_timers();
    start_program();
    emit(16'h6103);
    emit(16'hF115);
    emit(16'hF407); // Reads the delay timer before any frame has passed.
    emit(16'hF118);
    emit(16'hF207); // Polls the delay timer until it reaches zero.
    emit(16'h3200);
    emit(16'h1208);
    emit(16'hA300);
    emit(16'hF455);
    emit(16'hFFFF);
    apply_reset();
    wait_for_beep(100);
    check_byte("halted_o", byte_t'(halted_o), 8'h00);
    pulse_vsync();
    pulse_vsync();
    check_byte("beep_o", byte_t'(beep_o), 8'h01);
    check_byte("halted_o", byte_t'(halted_o), 8'h00);
    pulse_vsync();
    check_byte("beep_o", byte_t'(beep_o), 8'h00);
    wait_for_halt(200);
    check_mem(16'h0300, 8'h00);
    check_mem(16'h0301, 8'h03);
    check_mem(16'h0302, 8'h00);
    check_mem(16'h0303, 8'h00);
    check_mem(16'h0304, 8'h03);
    check_byte("beep_o", byte_t'(beep_o), 8'h00);
  endtask

  task automatic test_keypad();
    byte_t exp [6];
    exp = '{8'h00, 8'h00, 8'h00, 8'h09, 8'h05, 8'h17};
    start_program();
    emit(16'hF30A);
    emit(16'h6405);
    emit(16'hE49E); // Spins until key 5 is held.
    emit(16'h1204);
    emit(16'h6506);
    emit(16'hE5A1);
    emit(16'h65EE);
    emit(16'hE59E);
    emit(16'h7501);
    emit(16'hE4A1);
    emit(16'h7510);
    emit(16'hA300);
    emit(16'hF555);
    emit(16'hFFFF);
    apply_reset();
    // The first instruction is waiting for a key well before this press.
    repeat (20) @(negedge clk);
    key_matrix_i = 16'h0200;
    repeat (5) @(negedge clk);
    key_matrix_i = 16'h0000;
    repeat (10) @(negedge clk);
    check_byte("halted_o", byte_t'(halted_o), 8'h00);
    key_matrix_i = 16'h0020;
    wait_for_halt(500);
    key_matrix_i = 16'h0000;
    for (int k = 0; k < 6; k++)
      check_mem(16'h0300 + addr_t'(k), exp[k]);
  endtask

  task automatic test_illegal_opcode();
    start_program();
    emit(16'h6155);
    emit(16'hA300);
    emit(16'hF155);
    emit(16'h8128); // ALU code 8 does not exist.
    emit(16'h6177);
    emit(16'hF155);
    apply_reset();
    wait_for_halt(200);
    for (int k = 0; k < 40; k++)
    begin
      check_byte("halted_o", byte_t'(halted_o), 8'h01);
      check_byte("ram_we_o", byte_t'(ram_we_o), 8'h00);
      @(negedge clk);
    end
    check_mem(16'h0300, 8'h00);
    check_mem(16'h0301, 8'h55);
    check_addr("last write address", last_wr_addr, 16'h0301);
  endtask

  initial
  begin
    clk = 1'b0;
    rst_i = 1'b1;
    vsync_i = 1'b0;
    key_matrix_i = '0;
    ram_dout_i = '0;
    errors = 0;
    seed_ret = $urandom(1860);
    test_alu_flags();
    test_control_flow();
    test_memory_xfer();
    test_timers();
    test_keypad();
    test_illegal_opcode();
    if (errors == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule
